/* hw/cfg_pkg.sv */
package cfg_pkg;

    // Register index, taken from address bits 4..2.
    typedef enum logic [2:0] {
        R_SCR         = 3'd0,
        R_DD_OFFSET   = 3'd1,
        R_SAVE_OFFSET = 3'd2,
        R_COMMAND     = 3'd3,
        R_DATA_0      = 3'd4,
        R_DATA_1      = 3'd5,
        R_VERSION     = 3'd6,
        R_RECONFIGURE = 3'd7
    } reg_id_e;

    localparam logic [31:0] RECONFIGURE_MAGIC = 32'h5253_5446; // "RSTF".
    localparam logic [31:0] CFG_VERSION       = 32'h0002_0100;

    // SCR status bits, written through byte 3.
    localparam int SCR_CPU_READY = 31;
    localparam int SCR_CPU_BUSY  = 30;
    localparam int SCR_CMD_ERROR = 28;

    // SCR mode bits, written through byte 0.
    localparam int SCR_SKIP_BOOTLOADER  = 6;
    localparam int SCR_FLASHRAM_ENABLED = 5;
    localparam int SCR_SRAM_BANKED      = 4;
    localparam int SCR_SRAM_ENABLED     = 3;
    localparam int SCR_DD_ENABLED       = 2;
    localparam int SCR_SDRAM_WRITABLE   = 1;
    localparam int SCR_SDRAM_SWITCH     = 0;

    // Memory offsets are 26 bits wide.
    localparam int OFFSET_W = 26;

    // Host command code width.
    localparam int CMD_W = 8;

endpackage

/* hw/axil_cfg_slave.sv */
module axil_cfg_slave import cfg_pkg::*; (
    input  logic        sys,
    input  logic        rst_n,
    input  logic [31:0] s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic [3:0]  s_wstrb,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [31:0] s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    output logic        req,
    output logic        req_write,
    output reg_id_e     req_index,
    output logic [31:0] req_wdata,
    output logic [3:0]  req_wstrb,
    input  logic        ack,
    input  logic [31:0] rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_RESP
    } state_e;

    state_e state;
    logic   ar_hs;
    logic   aw_hs;
    logic   resp_done;

    // Reads win when both directions are pending.
    assign s_arready = (state == S_IDLE) && s_arvalid;
    assign s_awready = (state == S_IDLE) && s_awvalid && s_wvalid && !s_arvalid;
    assign s_wready  = s_awready; // AW and W are taken together.

    assign ar_hs = s_arvalid && s_arready;
    assign aw_hs = s_awvalid && s_awready && s_wvalid && s_wready;

    assign req      = (state == S_REQ);
    assign s_bvalid = (state == S_RESP) && req_write;
    assign s_rvalid = (state == S_RESP) && !req_write;
    assign s_bresp  = 2'b00;
    assign s_rresp  = 2'b00;

    assign resp_done = req_write ? s_bready : s_rready;

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            req_write <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ar_hs) begin
                        req_write <= 1'b0;
                        state     <= S_REQ;
                    end else if (aw_hs) begin
                        req_write <= 1'b1;
                        state     <= S_REQ;
                    end
                end
                S_REQ: state <= S_WAIT;
                S_WAIT: begin
                    if (ack) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (resp_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request payload and read data.
    always_ff @(posedge sys) begin
        if (ar_hs) begin
            req_index <= reg_id_e'(s_araddr[4:2]);
            req_wstrb <= 4'b0000;
        end else if (aw_hs) begin
            req_index <= reg_id_e'(s_awaddr[4:2]);
            req_wdata <= s_wdata;
            req_wstrb <= s_wstrb;
        end
        if ((state == S_WAIT) && ack && !req_write) begin
            s_rdata <= rdata;
        end
    end

    bvalid_hold: assert property (@(posedge sys) disable iff (!rst_n)
        s_bvalid && !s_bready |=> s_bvalid);

    rvalid_hold: assert property (@(posedge sys) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

    no_req_in_resp: assert property (@(posedge sys) disable iff (!rst_n)
        req |-> !s_bvalid && !s_rvalid && !$past(s_bvalid || s_rvalid));

endmodule

/* hw/cpu_cfg.sv */
module cpu_cfg import cfg_pkg::*; #(
    parameter logic [OFFSET_W-1:0] DD_OFFSET_RESET   = 26'h3BE_0000,
    parameter logic [OFFSET_W-1:0] SAVE_OFFSET_RESET = 26'h3FE_0000
) (
    input  logic                sys,
    input  logic                rst_n,
    input  logic                req,
    input  logic                req_write,
    input  reg_id_e             req_index,
    input  logic [31:0]         req_wdata,
    input  logic [3:0]          req_wstrb,
    output logic                ack,
    output logic [31:0]         rdata,
    input  logic                soft_reset,
    input  logic                cmd_request,
    input  logic [CMD_W-1:0]    cmd_code,
    input  logic [31:0]         data0,
    input  logic [31:0]         data1,
    output logic                cpu_busy,
    output logic                cmd_error,
    output logic [1:0]          data_write,
    output logic [31:0]         data_wdata,
    output logic                cpu_ready,
    output logic                sdram_switch,
    output logic                sdram_writable,
    output logic                dd_enabled,
    output logic                sram_enabled,
    output logic                sram_banked,
    output logic                flashram_enabled,
    output logic [OFFSET_W-1:0] dd_offset,
    output logic [OFFSET_W-1:0] save_offset,
    output logic                reconfig_armed
);

    logic        skip_bootloader;
    logic        wr;
    logic        wr_full;
    logic [31:0] scr_word;
    logic [31:0] read_word;

    assign wr      = req && req_write;
    assign wr_full = wr && (&req_wstrb);

    always_comb begin
        scr_word                       = 32'd0;
        scr_word[SCR_CPU_READY]        = cpu_ready;
        scr_word[SCR_CPU_BUSY]         = cpu_busy;
        scr_word[SCR_CMD_ERROR]        = cmd_error;
        scr_word[SCR_SKIP_BOOTLOADER]  = skip_bootloader;
        scr_word[SCR_FLASHRAM_ENABLED] = flashram_enabled;
        scr_word[SCR_SRAM_BANKED]      = sram_banked;
        scr_word[SCR_SRAM_ENABLED]     = sram_enabled;
        scr_word[SCR_DD_ENABLED]       = dd_enabled;
        scr_word[SCR_SDRAM_WRITABLE]   = sdram_writable;
        scr_word[SCR_SDRAM_SWITCH]     = sdram_switch;
    end

    always_comb begin
        case (req_index)
            R_SCR:         read_word = scr_word;
            R_DD_OFFSET:   read_word = {{(32-OFFSET_W){1'b0}}, dd_offset};
            R_SAVE_OFFSET: read_word = {{(32-OFFSET_W){1'b0}}, save_offset};
            R_COMMAND:     read_word = {{(32-CMD_W){1'b0}}, cmd_code};
            R_DATA_0:      read_word = data0;
            R_DATA_1:      read_word = data1;
            R_VERSION:     read_word = CFG_VERSION;
            R_RECONFIGURE: read_word = {31'd0, reconfig_armed};
            default:       read_word = 32'd0;
        endcase
    end

    // Mailbox data words live in cmd_mailbox.
    assign data_wdata    = req_wdata;
    assign data_write[0] = wr_full && (req_index == R_DATA_0);
    assign data_write[1] = wr_full && (req_index == R_DATA_1);

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    always_ff @(posedge sys) begin
        if (req) begin
            rdata <= read_word; // Held for the ack cycle.
        end
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            cpu_ready        <= 1'b0;
            cpu_busy         <= 1'b0;
            cmd_error        <= 1'b0;
            skip_bootloader  <= 1'b0;
            flashram_enabled <= 1'b0;
            sram_banked      <= 1'b0;
            sram_enabled     <= 1'b0;
            dd_enabled       <= 1'b0;
            sdram_writable   <= 1'b0;
            sdram_switch     <= 1'b0;
            dd_offset        <= DD_OFFSET_RESET;
            save_offset      <= SAVE_OFFSET_RESET;
            reconfig_armed   <= 1'b0;
        end else begin
            // Console reset returns to the bootloader unless skipped.
            if (soft_reset) begin
                sdram_switch   <= skip_bootloader;
                sdram_writable <= 1'b0;
            end
            if (cmd_request) begin
                cpu_busy <= 1'b1;
            end
            if (wr && (req_index == R_SCR)) begin
                if (req_wstrb[3]) begin
                    cpu_ready <= req_wdata[SCR_CPU_READY];
                    cpu_busy  <= req_wdata[SCR_CPU_BUSY];
                    cmd_error <= req_wdata[SCR_CMD_ERROR];
                end
                if (req_wstrb[0]) begin
                    skip_bootloader  <= req_wdata[SCR_SKIP_BOOTLOADER];
                    flashram_enabled <= req_wdata[SCR_FLASHRAM_ENABLED];
                    sram_banked      <= req_wdata[SCR_SRAM_BANKED];
                    sram_enabled     <= req_wdata[SCR_SRAM_ENABLED];
                    dd_enabled       <= req_wdata[SCR_DD_ENABLED];
                    sdram_writable   <= req_wdata[SCR_SDRAM_WRITABLE];
                    sdram_switch     <= req_wdata[SCR_SDRAM_SWITCH];
                end
            end
            if (wr_full) begin
                case (req_index)
                    R_DD_OFFSET:   dd_offset   <= req_wdata[OFFSET_W-1:0];
                    R_SAVE_OFFSET: save_offset <= req_wdata[OFFSET_W-1:0];
                    R_RECONFIGURE: begin
                        if (req_wdata == RECONFIGURE_MAGIC) begin
                            reconfig_armed <= 1'b1; // Sticky until reset.
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    ack_after_req: assert property (@(posedge sys) disable iff (!rst_n)
        req |=> ack);

endmodule

/* hw/cmd_mailbox.sv */
module cmd_mailbox (
    input  logic        sys,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  logic [7:0]  cmd_code_in,
    input  logic [31:0] cmd_arg0,
    input  logic [31:0] cmd_arg1,
    output logic        cmd_ready,
    output logic        cmd_request,
    output logic [7:0]  cmd_code,
    output logic [31:0] data0,
    output logic [31:0] data1,
    input  logic        cpu_busy,
    input  logic        cmd_error,
    input  logic [1:0]  data_write,
    input  logic [31:0] data_wdata,
    output logic        rsp_valid,
    output logic        rsp_error,
    output logic [31:0] rsp_data0,
    output logic [31:0] rsp_data1
);

    logic accept;
    logic busy_q;
    logic busy_fall;

    assign cmd_ready = !cpu_busy;
    assign accept    = cmd_valid && cmd_ready;
    assign busy_fall = busy_q && !cpu_busy;

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            cmd_request <= 1'b0;
            busy_q      <= 1'b0;
            rsp_valid   <= 1'b0;
        end else begin
            cmd_request <= accept;
            busy_q      <= cpu_busy;
            rsp_valid   <= busy_fall; // CPU finished the command.
        end
    end

    // Host arguments land in the data words, CPU writes overwrite them.
    always_ff @(posedge sys) begin
        if (accept) begin
            cmd_code <= cmd_code_in;
            data0    <= cmd_arg0;
            data1    <= cmd_arg1;
        end else begin
            if (data_write[0]) begin
                data0 <= data_wdata;
            end
            if (data_write[1]) begin
                data1 <= data_wdata;
            end
        end
        if (busy_fall) begin
            rsp_error <= cmd_error;
            rsp_data0 <= data0;
            rsp_data1 <= data1;
        end
    end

endmodule

/* hw/reconfig_sequencer.sv */
module reconfig_sequencer (
    input  logic sys,
    input  logic rst_n,
    input  logic reconfig_armed,
    output logic reconfig_clk,
    output logic reconfig_write
);

    logic write_done;

    // Strobe changes only while the slow clock is low, so the
    // configuration controller sees it for one whole period.
    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            reconfig_clk   <= 1'b0;
            reconfig_write <= 1'b0;
            write_done     <= 1'b0;
        end else begin
            reconfig_clk <= ~reconfig_clk;
            if (!reconfig_clk) begin
                reconfig_write <= 1'b0;
                if (reconfig_armed && !write_done) begin
                    reconfig_write <= 1'b1;
                    write_done     <= 1'b1;
                end
            end
        end
    end

    single_strobe: assert property (@(posedge sys) disable iff (!rst_n)
        $rose(reconfig_write) |-> !$past(write_done) && $past(reconfig_armed));

    strobe_width: assert property (@(posedge sys) disable iff (!rst_n)
        $rose(reconfig_write) |=> reconfig_write ##1 !reconfig_write);

endmodule

/* hw/cfg_top.sv */
module cfg_top import cfg_pkg::*; #(
    parameter logic [OFFSET_W-1:0] DD_OFFSET_RESET   = 26'h3BE_0000,
    parameter logic [OFFSET_W-1:0] SAVE_OFFSET_RESET = 26'h3FE_0000
) (
    input  logic                sys,
    input  logic                rst_n,
    input  logic [31:0]         s_awaddr,
    input  logic                s_awvalid,
    output logic                s_awready,
    input  logic [31:0]         s_wdata,
    input  logic [3:0]          s_wstrb,
    input  logic                s_wvalid,
    output logic                s_wready,
    output logic [1:0]          s_bresp,
    output logic                s_bvalid,
    input  logic                s_bready,
    input  logic [31:0]         s_araddr,
    input  logic                s_arvalid,
    output logic                s_arready,
    output logic [31:0]         s_rdata,
    output logic [1:0]          s_rresp,
    output logic                s_rvalid,
    input  logic                s_rready,
    input  logic                soft_reset,
    input  logic                cmd_valid,
    input  logic [CMD_W-1:0]    cmd_code_in,
    input  logic [31:0]         cmd_arg0,
    input  logic [31:0]         cmd_arg1,
    output logic                cmd_ready,
    output logic                rsp_valid,
    output logic                rsp_error,
    output logic [31:0]         rsp_data0,
    output logic [31:0]         rsp_data1,
    output logic                cpu_ready,
    output logic                sdram_switch,
    output logic                sdram_writable,
    output logic                dd_enabled,
    output logic                sram_enabled,
    output logic                sram_banked,
    output logic                flashram_enabled,
    output logic [OFFSET_W-1:0] dd_offset,
    output logic [OFFSET_W-1:0] save_offset,
    output logic                reconfig_clk,
    output logic                reconfig_write
);

    logic             req, req_write, ack;
    reg_id_e          req_index;
    logic [31:0]      req_wdata, rdata;
    logic [3:0]       req_wstrb;
    logic             cmd_request, cpu_busy, cmd_error, reconfig_armed;
    logic [CMD_W-1:0] cmd_code;
    logic [1:0]       data_write;
    logic [31:0]      data_wdata, data0, data1;

    axil_cfg_slave i_slave (.*);

    cpu_cfg #(
        .DD_OFFSET_RESET   (DD_OFFSET_RESET),
        .SAVE_OFFSET_RESET (SAVE_OFFSET_RESET)
    ) i_regs (.*);

    cmd_mailbox i_mailbox (.*);

    reconfig_sequencer i_reconfig (.*);

endmodule

/* verif/tb_axil_bfm.svh */
`ifndef TB_AXIL_BFM_SVH
`define TB_AXIL_BFM_SVH

// Byte address of a register index.
function automatic logic [31:0] addr_of(input reg_id_e idx);
    return {27'd0, idx, 2'b00};
endfunction

// One AXI4-Lite write. bready stays low for stall cycles after bvalid.
task automatic write_reg(input reg_id_e idx, input logic [31:0] data,
                         input logic [3:0] strb, input int stall);
    s_awaddr  <= addr_of(idx);
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strb;
    s_wvalid  <= 1'b1;
    @(posedge sys);
    while (!(s_awready && s_wready)) begin
        @(posedge sys);
    end
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    do begin
        @(posedge sys);
    end while (!s_bvalid);
    repeat (stall) @(posedge sys);
    s_bready <= 1'b1;
    @(posedge sys);
    s_bready <= 1'b0;
endtask

// One AXI4-Lite read. The read data check compares against expected under mask.
task automatic read_check(input reg_id_e idx, input logic [31:0] expected,
                          input logic [31:0] mask, input int stall);
    exp_rdata  = expected;
    exp_mask   = mask;
    s_araddr  <= addr_of(idx);
    s_arvalid <= 1'b1;
    @(posedge sys);
    while (!s_arready) begin
        @(posedge sys);
    end
    s_arvalid <= 1'b0;
    do begin
        @(posedge sys);
    end while (!s_rvalid);
    repeat (stall) @(posedge sys);
    s_rready <= 1'b1;
    @(posedge sys);
    s_rready <= 1'b0;
endtask

`endif

/* verif/tb_cfg_top.sv */
module tb_cfg_top import cfg_pkg::*; ();

    localparam logic [OFFSET_W-1:0] DD_RESET   = 26'h3BE_0000;
    localparam logic [OFFSET_W-1:0] SAVE_RESET = 26'h3FE_0000;
    localparam int WATCHDOG_CYCLES = 4000; // About 40 transfers of under 40 cycles, with margin.

    logic                sys, rst_n, soft_reset;
    logic [31:0]         s_awaddr, s_wdata, s_araddr, s_rdata;
    logic                s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic                s_arvalid, s_arready, s_rvalid, s_rready;
    logic [3:0]          s_wstrb;
    logic [1:0]          s_bresp, s_rresp;
    logic                cmd_valid, cmd_ready, rsp_valid, rsp_error;
    logic [CMD_W-1:0]    cmd_code_in;
    logic [31:0]         cmd_arg0, cmd_arg1, rsp_data0, rsp_data1;
    logic                cpu_ready, sdram_switch, sdram_writable, dd_enabled;
    logic                sram_enabled, sram_banked, flashram_enabled;
    logic [OFFSET_W-1:0] dd_offset, save_offset;
    logic                reconfig_clk, reconfig_write;

    // Expected values and test phase flags.
    int                  seed          = 28750;
    logic [31:0]         exp_rdata     = '0;
    logic [31:0]         exp_mask      = '0;
    logic [6:0]          exp_mode      = '0;
    logic                exp_ready     = 1'b0;
    logic [OFFSET_W-1:0] exp_dd        = DD_RESET;
    logic [OFFSET_W-1:0] exp_save      = SAVE_RESET;
    logic                mode_check    = 1'b0;
    logic                host_cmd_sent = 1'b0;
    logic                magic_sent    = 1'b0;
    logic                exp_rsp_error = 1'b0;
    logic [31:0]         exp_rsp0      = '0;
    logic [31:0]         exp_rsp1      = '0;
    int                  rsp_count     = 0;
    int                  strobe_count  = 0;
    logic                write_q       = 1'b0;
    logic [31:0]         rnd, arg0, arg1, new1;
    int                  stall;
    int                  rd_stall;

    cfg_top #(
        .DD_OFFSET_RESET   (DD_RESET),
        .SAVE_OFFSET_RESET (SAVE_RESET)
    ) i_dut (.*);

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("MISMATCH at time %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    `include "tb_axil_bfm.svh"

    // Byte-0 SCR write, then the mode ports must follow.
    task automatic write_mode(input logic [31:0] data);
        mode_check = 1'b0;
        write_reg(R_SCR, data, 4'b0001, 0);
        exp_mode   = data[6:0];
        mode_check = 1'b1;
    endtask

    initial begin
        sys = 1'b0;
        forever #50 sys = ~sys;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys);
        stop_run("Timeout: the tests did not finish within the cycle limit.");
    end

    always @(posedge sys) begin
        if (rsp_valid) begin
            rsp_count++;
        end
        if (reconfig_write && !write_q) begin
            strobe_count++;
        end
        write_q <= reconfig_write;
    end

    read_data_ok: assert property (@(posedge sys) disable iff (!rst_n)
        s_rvalid && s_rready |-> ((s_rdata ^ exp_rdata) & exp_mask) == 32'd0)
        else report_mismatch($sformatf("read data %h, expected %h", s_rdata, exp_rdata));

    offset_ports: assert property (@(posedge sys) disable iff (!rst_n)
        s_rvalid && s_rready |-> dd_offset == exp_dd && save_offset == exp_save)
        else report_mismatch("offset ports differ from the written offsets");

    resp_okay: assert property (@(posedge sys) disable iff (!rst_n)
        s_bvalid || s_rvalid |-> s_bresp == 2'b00 && s_rresp == 2'b00)
        else report_mismatch("response is not OKAY");

    bvalid_held: assert property (@(posedge sys) disable iff (!rst_n)
        s_bvalid && !s_bready |=> s_bvalid)
        else report_mismatch("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge sys) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else report_mismatch("rvalid or rdata changed before rready");

    no_accept_pending: assert property (@(posedge sys) disable iff (!rst_n)
        s_bvalid || s_rvalid |-> !s_awready && !s_wready && !s_arready)
        else report_mismatch("address ready while a response is pending");

    write_latency: assert property (@(posedge sys) disable iff (!rst_n)
        s_awvalid && s_awready && s_wvalid && s_wready |-> ##3 s_bvalid)
        else report_mismatch("bvalid not 3 cycles after the write handshake");

    read_latency: assert property (@(posedge sys) disable iff (!rst_n)
        s_arvalid && s_arready |-> ##3 s_rvalid)
        else report_mismatch("rvalid not 3 cycles after the read handshake");

    mode_ports: assert property (@(posedge sys) disable iff (!rst_n)
        mode_check |-> {cpu_ready, flashram_enabled, sram_banked, sram_enabled, dd_enabled,
                        sdram_writable, sdram_switch} == {exp_ready, exp_mode[5:0]})
        else report_mismatch("mode bit ports differ from the SCR mode bits");

    soft_reset_effect: assert property (@(posedge sys) disable iff (!rst_n)
        soft_reset |=> !sdram_writable && sdram_switch == exp_mode[SCR_SKIP_BOOTLOADER])
        else report_mismatch("soft reset did not reload sdram_switch and sdram_writable");

    ready_before_cmd: assert property (@(posedge sys) disable iff (!rst_n)
        !host_cmd_sent |-> cmd_ready)
        else report_mismatch("cmd_ready low with no command sent");

    busy_after_cmd: assert property (@(posedge sys) disable iff (!rst_n)
        cmd_valid && cmd_ready |-> ##2 !cmd_ready)
        else report_mismatch("cmd_ready did not fall after command acceptance");

    reply_fields: assert property (@(posedge sys) disable iff (!rst_n)
        rsp_valid |-> rsp_error == exp_rsp_error && rsp_data0 == exp_rsp0
                      && rsp_data1 == exp_rsp1)
        else report_mismatch("reply error flag or data words are wrong");

    reply_single: assert property (@(posedge sys) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid)
        else report_mismatch("rsp_valid longer than one cycle");

    slow_clock_toggles: assert property (@(posedge sys) disable iff (!rst_n)
        $past(rst_n) |-> reconfig_clk != $past(reconfig_clk))
        else report_mismatch("reconfig_clk did not toggle");

    strobe_after_magic: assert property (@(posedge sys) disable iff (!rst_n)
        !magic_sent |-> !reconfig_write)
        else report_mismatch("reconfig_write without the magic word");

    strobe_width: assert property (@(posedge sys) disable iff (!rst_n)
        $rose(reconfig_write) |=> reconfig_write ##1 !reconfig_write)
        else report_mismatch("reconfig_write not exactly 2 cycles wide");

    initial begin
        rst_n       <= 1'b0;
        soft_reset  <= 1'b0;
        s_awaddr    <= '0;
        s_awvalid   <= 1'b0;
        s_wdata     <= '0;
        s_wstrb     <= '0;
        s_wvalid    <= 1'b0;
        s_bready    <= 1'b0;
        s_araddr    <= '0;
        s_arvalid   <= 1'b0;
        s_rready    <= 1'b0;
        cmd_valid   <= 1'b0;
        cmd_code_in <= '0;
        cmd_arg0    <= '0;
        cmd_arg1    <= '0;
        repeat (16) @(posedge sys);
        rst_n <= 1'b1;
        @(posedge sys);

        // Reset values.
        read_check(R_SCR, 32'd0, '1, 0);
        read_check(R_DD_OFFSET, {6'd0, DD_RESET}, '1, 0);
        read_check(R_SAVE_OFFSET, {6'd0, SAVE_RESET}, '1, 0);
        read_check(R_VERSION, CFG_VERSION, '1, 0);
        read_check(R_RECONFIGURE, 32'd0, '1, 0);

        // Byte strobes.
        rnd = next_rand();
        write_mode(rnd);
        read_check(R_SCR, {25'd0, rnd[6:0]}, '1, 0);
        rnd = next_rand();
        write_reg(R_DD_OFFSET, rnd, 4'b0111, 0);
        read_check(R_DD_OFFSET, {6'd0, DD_RESET}, '1, 0);
        write_reg(R_DD_OFFSET, rnd, 4'b1111, 0);
        exp_dd = rnd[25:0];
        read_check(R_DD_OFFSET, {6'd0, rnd[25:0]}, '1, 0);

        write_mode(32'h0000_0042); // Skip and writable set, switch clear.
        mode_check  = 1'b0;
        soft_reset <= 1'b1;
        @(posedge sys);
        soft_reset <= 1'b0;
        @(posedge sys);
        exp_mode[SCR_SDRAM_SWITCH]   = exp_mode[SCR_SKIP_BOOTLOADER];
        exp_mode[SCR_SDRAM_WRITABLE] = 1'b0;
        mode_check = 1'b1;
        read_check(R_SCR, {25'd0, exp_mode}, '1, 0);

        // Host command round trip.
        rnd  = next_rand();
        arg0 = next_rand();
        arg1 = next_rand();
        host_cmd_sent = 1'b1;
        cmd_valid   <= 1'b1;
        cmd_code_in <= rnd[7:0];
        cmd_arg0    <= arg0;
        cmd_arg1    <= arg1;
        @(posedge sys);
        while (!cmd_ready) begin
            @(posedge sys);
        end
        cmd_valid <= 1'b0;
        read_check(R_SCR, 32'h4000_0000, 32'h4000_0000, 0);
        read_check(R_COMMAND, {24'd0, rnd[7:0]}, '1, 0);
        read_check(R_DATA_0, arg0, '1, 0);
        read_check(R_DATA_1, arg1, '1, 0);
        new1 = next_rand();
        write_reg(R_DATA_1, new1, 4'b1111, 0);
        exp_rsp_error = 1'b1;
        exp_rsp0      = arg0;
        exp_rsp1      = new1;
        mode_check    = 1'b0;
        write_reg(R_SCR, 32'h9000_0000, 4'b1000, 0); // Ready and error set, busy clear.
        exp_ready     = 1'b1;
        mode_check    = 1'b1;
        while (rsp_count == 0) begin
            @(posedge sys);
        end

        // Reconfiguration arm.
        rnd = next_rand();
        if (rnd == RECONFIGURE_MAGIC) begin
            rnd = ~rnd;
        end
        write_reg(R_RECONFIGURE, rnd, 4'b1111, 0);
        read_check(R_RECONFIGURE, 32'd0, '1, 0);
        repeat (4) @(posedge sys);
        magic_sent = 1'b1;
        write_reg(R_RECONFIGURE, RECONFIGURE_MAGIC, 4'b1111, 0);
        read_check(R_RECONFIGURE, 32'd1, '1, 0);
        while (strobe_count == 0) begin
            @(posedge sys);
        end
        repeat (8) @(posedge sys);

        // Back-pressure on both response channels, read queued behind the write.
        repeat (4) begin
            rnd      = next_rand();
            stall    = 1 + rnd[28:26];
            rd_stall = 1 + rnd[31:29];
            exp_save = rnd[25:0];
            fork
                write_reg(R_SAVE_OFFSET, rnd, 4'b1111, stall);
                begin
                    do begin
                        @(posedge sys);
                    end while (!s_bvalid);
                    read_check(R_SAVE_OFFSET, {6'd0, rnd[25:0]}, '1, rd_stall);
                end
            join
        end

        repeat (4) @(posedge sys);
        if (rsp_count != 1 || strobe_count != 1) begin
            stop_run($sformatf("Expected one reply and one strobe, saw %0d and %0d.",
                               rsp_count, strobe_count));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+verif
hw/cfg_pkg.sv
hw/axil_cfg_slave.sv
hw/cpu_cfg.sv
hw/cmd_mailbox.sv
hw/reconfig_sequencer.sv
hw/cfg_top.sv
verif/tb_cfg_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cfg_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard verif/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
